// ==== Makefile ====
# Verilator simulation of the reduced 6502 core

TOP       ?= cpu_tb
FILELIST  ?= list.f
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/10ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_alu.sv
rtl/cpu_decode.sv
rtl/cpu_sequencer.sv
rtl/cpu_pc.sv
rtl/cpu_regs.sv
rtl/cpu_top.sv
verification/cpu_tb.sv

// ==== rtl/cpu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_alu (
    input  var cpu_pkg::alu_op_e i_op,
    input  var cpu_pkg::data_t   i_a,
    input  var cpu_pkg::data_t   i_b,
    input  wire                  i_carry,
    output cpu_pkg::data_t       o_out,
    output logic                 o_n,
    output logic                 o_v,
    output logic                 o_z,
    output logic                 o_c
);

    cpu_pkg::data_t b_eff;          // b after inversion for SBC
    logic [8:0]     sum;            // adder with carry out

    assign b_eff = (i_op == cpu_pkg::ALU_SBC) ? ~i_b : i_b;
    assign sum   = {1'b0, i_a} + {1'b0, b_eff} + {8'd0, i_carry};

    always_comb begin
        o_out = i_b;
        o_c   = i_carry;            // logic ops keep carry
        o_v   = 1'b0;
        case (i_op)
            cpu_pkg::ALU_ADC,
            cpu_pkg::ALU_SBC: begin
                o_out = sum[7:0];
                o_c   = sum[8];
                // signed overflow when the input signs match and the result sign differs
                o_v   = (i_a[7] == b_eff[7]) && (sum[7] != i_a[7]);
            end
            cpu_pkg::ALU_AND:  o_out = i_a & i_b;
            cpu_pkg::ALU_ORA:  o_out = i_a | i_b;
            cpu_pkg::ALU_EOR:  o_out = i_a ^ i_b;
            cpu_pkg::ALU_PASS: o_out = i_b;
            cpu_pkg::ALU_INC:  o_out = i_a + 8'd1;
            cpu_pkg::ALU_DEC:  o_out = i_a - 8'd1;
            default:           o_out = i_b;
        endcase
    end

    assign o_n = o_out[7];
    assign o_z = (o_out == '0);

endmodule

`default_nettype wire

// ==== rtl/cpu_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_decode (
    input  var cpu_pkg::data_t i_opcode,
    output cpu_pkg::mode_e     o_mode,
    output cpu_pkg::alu_op_e   o_alu_op,
    output cpu_pkg::dst_e      o_dst,
    output logic               o_uses_x,
    output logic               o_set_c,
    output logic               o_set_v,
    output logic               o_flag_c_force,
    output logic               o_valid
);

    cpu_pkg::mode_e mem_mode;       // mode from bits 4:2 of memory opcodes

    assign mem_mode = (i_opcode[4:2] == 3'b011) ? cpu_pkg::MODE_ABS :
                      (i_opcode[4:2] == 3'b001) ? cpu_pkg::MODE_ZPG :
                                                  cpu_pkg::MODE_IMM;

    always_comb begin
        o_mode         = mem_mode;
        o_alu_op       = cpu_pkg::ALU_PASS;
        o_dst          = cpu_pkg::DST_NONE;
        o_uses_x       = 1'b0;
        o_set_c        = 1'b0;
        o_set_v        = 1'b0;
        o_flag_c_force = 1'b0;
        o_valid        = 1'b1;
        case (i_opcode)
            8'h69, 8'h65, 8'h6d: begin    // ADC
                o_alu_op = cpu_pkg::ALU_ADC;
                o_dst    = cpu_pkg::DST_A;
                o_set_c  = 1'b1;
                o_set_v  = 1'b1;
            end
            8'he9, 8'he5, 8'hed: begin    // SBC
                o_alu_op = cpu_pkg::ALU_SBC;
                o_dst    = cpu_pkg::DST_A;
                o_set_c  = 1'b1;
                o_set_v  = 1'b1;
            end
            8'h29, 8'h25, 8'h2d: begin
                o_alu_op = cpu_pkg::ALU_AND;
                o_dst    = cpu_pkg::DST_A;
            end
            8'h09, 8'h05, 8'h0d: begin
                o_alu_op = cpu_pkg::ALU_ORA;
                o_dst    = cpu_pkg::DST_A;
            end
            8'h49, 8'h45, 8'h4d: begin
                o_alu_op = cpu_pkg::ALU_EOR;
                o_dst    = cpu_pkg::DST_A;
            end
            8'ha9, 8'ha5, 8'had: o_dst = cpu_pkg::DST_A;     // LDA
            8'ha2, 8'ha6, 8'hae: o_dst = cpu_pkg::DST_X;     // LDX
            8'h85, 8'h8d:        o_dst = cpu_pkg::DST_MEM;   // STA
            8'h86, 8'h8e: begin                              // STX
                o_dst    = cpu_pkg::DST_MEM;
                o_uses_x = 1'b1;
            end
            8'he8, 8'hca: begin                              // INX, DEX
                o_mode   = cpu_pkg::MODE_IMPL;
                o_alu_op = i_opcode[5] ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
                o_dst    = cpu_pkg::DST_X;
                o_uses_x = 1'b1;
            end
            8'haa: begin                                     // TAX
                o_mode = cpu_pkg::MODE_IMPL;
                o_dst  = cpu_pkg::DST_X;
            end
            8'h8a: begin                                     // TXA
                o_mode   = cpu_pkg::MODE_IMPL;
                o_dst    = cpu_pkg::DST_A;
                o_uses_x = 1'b1;
            end
            8'h18, 8'h38: begin                              // CLC, SEC
                o_mode         = cpu_pkg::MODE_IMPL;
                o_set_c        = 1'b1;
                o_flag_c_force = 1'b1;
            end
            8'h4c:   o_mode = cpu_pkg::MODE_JMP;
            default: begin
                o_mode  = cpu_pkg::MODE_IMPL;
                o_valid = 1'b0;                              // core jams
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_pc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_pc (
    input  wire                i_clk,
    input  wire                i_rst,
    input  wire                i_rdy,
    input  wire                i_inc_pc,
    input  wire                i_jump,
    input  wire                i_load_op,
    input  var cpu_pkg::mode_e i_addr_sel,
    input  var cpu_pkg::data_t i_mem_data,
    output cpu_pkg::addr_t     o_addr
);

    cpu_pkg::addr_t pc;
    cpu_pkg::data_t adl;            // low byte of absolute address

    always_comb begin
        case (i_addr_sel)
            cpu_pkg::MODE_ZPG: o_addr = {`CPU_ZPG_PAGE, i_mem_data};
            cpu_pkg::MODE_ABS: o_addr = {i_mem_data, adl};   // high byte straight from bus
            default:           o_addr = pc;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= `CPU_START_ADDR;
        end else if (i_rdy) begin
            if (i_jump) begin
                pc <= o_addr + 16'd1;     // target fetched this cycle
            end else if (i_inc_pc) begin
                pc <= pc + 16'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rdy && i_load_op) begin
            adl <= i_mem_data;
        end
    end

    // a stalled read keeps its address on the bus
    a_addr_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_rdy |=> $stable(o_addr));

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;    // one memory byte
    typedef logic [`CPU_ADDR_W-1:0] addr_t;    // one memory address
    typedef logic [7:0]             flags_t;   // N V - - - - Z C

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_ZPG,
        ST_ABS_LO,
        ST_ABS_HI,
        ST_JMP_HI,
        ST_JAM
    } state_e;

    typedef enum logic [2:0] {
        MODE_IMPL,
        MODE_IMM,
        MODE_ZPG,
        MODE_ABS,
        MODE_JMP
    } mode_e;

    typedef enum logic [2:0] {
        ALU_ADC,
        ALU_SBC,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_PASS,
        ALU_INC,
        ALU_DEC
    } alu_op_e;

    typedef enum logic [1:0] {
        DST_NONE,
        DST_A,
        DST_X,
        DST_MEM
    } dst_e;

endpackage

`default_nettype wire

// ==== rtl/cpu_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_regs (
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  var cpu_pkg::data_t  i_data,
    input  wire                 i_ready,
    input  wire                 i_rw,
    input  var cpu_pkg::state_e i_state,
    input  wire                 i_exec,
    input  wire                 i_write_mem,
    input  var cpu_pkg::dst_e   i_dst,
    input  wire                 i_uses_x,
    input  wire                 i_set_c,
    input  wire                 i_set_v,
    input  wire                 i_flag_c_force,
    input  var cpu_pkg::data_t  i_alu_out,
    input  wire                 i_alu_n,
    input  wire                 i_alu_v,
    input  wire                 i_alu_z,
    input  wire                 i_alu_c,
    output logic                o_rdy,
    output cpu_pkg::data_t      o_mem_data,
    output cpu_pkg::data_t      o_opcode,
    output cpu_pkg::data_t      o_alu_a,
    output cpu_pkg::data_t      o_alu_b,
    output logic                o_carry,
    output cpu_pkg::data_t      o_dor
);

    logic            rdy_r;         // last cycle's read completed
    cpu_pkg::data_t  data_hold;
    cpu_pkg::data_t  ir;
    cpu_pkg::data_t  a;
    cpu_pkg::data_t  x;
    cpu_pkg::flags_t p;
    logic            in_decode;
    logic            to_reg;

    assign o_rdy      = i_ready || !i_rw;                // writes never wait
    assign o_mem_data = rdy_r ? i_data : data_hold;
    assign in_decode  = (i_state == cpu_pkg::ST_DECODE);
    assign o_opcode   = in_decode ? o_mem_data : ir;     // opcode arrives in decode

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rdy_r <= 1'b0;
        end else begin
            rdy_r <= o_rdy;
        end
    end

    always_ff @(posedge i_clk) begin
        data_hold <= o_mem_data;
        if (o_rdy && in_decode) begin
            ir <= o_mem_data;
        end
    end

    assign o_alu_a = i_uses_x ? x : a;
    // implied ops execute in decode and take a register as b
    assign o_alu_b = in_decode ? o_alu_a : o_mem_data;
    // CLC and SEC differ only in opcode bit 5
    assign o_carry = i_flag_c_force ? o_opcode[5] : p[0];
    assign o_dor   = o_alu_a;
    assign to_reg  = (i_dst == cpu_pkg::DST_A) || (i_dst == cpu_pkg::DST_X);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            a <= '0;
            x <= '0;
            p <= '0;
        end else if (o_rdy && i_exec) begin
            if (i_dst == cpu_pkg::DST_A) a <= i_alu_out;
            if (i_dst == cpu_pkg::DST_X) x <= i_alu_out;
            if (to_reg) begin
                p[7] <= i_alu_n;
                p[1] <= i_alu_z;
            end
            if (i_set_v) p[6] <= i_alu_v;
            if (i_set_c) p[0] <= i_alu_c;
        end
    end

    a_exec_or_store: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_exec && i_write_mem));

endmodule

`default_nettype wire

// ==== rtl/cpu_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_sequencer (
    input  wire                i_clk,
    input  wire                i_rst,
    input  wire                i_rdy,
    input  var cpu_pkg::mode_e i_mode,
    input  wire                i_valid,
    input  var cpu_pkg::dst_e  i_dst,
    output logic               o_fetch,
    output logic               o_inc_pc,
    output logic               o_load_op,
    output cpu_pkg::mode_e     o_addr_sel,
    output logic               o_exec,
    output logic               o_write_mem,
    output logic               o_rw,
    output logic               o_jump,
    output logic               o_jam,
    output cpu_pkg::state_e    o_state
);

    cpu_pkg::state_e state;
    logic            pend_exec;     // load result arrives during next fetch
    logic            pend_jump;     // jump target completes during next fetch
    logic            is_store;

    assign is_store = (i_dst == cpu_pkg::DST_MEM);
    assign o_state  = state;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= cpu_pkg::ST_FETCH;
            pend_exec <= 1'b0;
            pend_jump <= 1'b0;
        end else if (i_rdy) begin
            pend_exec <= ((state == cpu_pkg::ST_DECODE) && i_valid
                          && (i_mode == cpu_pkg::MODE_IMM))
                      || (((state == cpu_pkg::ST_ZPG) || (state == cpu_pkg::ST_ABS_HI))
                          && !is_store);
            pend_jump <= (state == cpu_pkg::ST_JMP_HI);
            case (state)
                cpu_pkg::ST_FETCH: state <= cpu_pkg::ST_DECODE;
                cpu_pkg::ST_DECODE: begin
                    if (!i_valid) begin
                        state <= cpu_pkg::ST_JAM;
                    end else begin
                        case (i_mode)
                            cpu_pkg::MODE_ZPG: state <= cpu_pkg::ST_ZPG;
                            cpu_pkg::MODE_ABS: state <= cpu_pkg::ST_ABS_LO;
                            cpu_pkg::MODE_JMP: state <= cpu_pkg::ST_JMP_HI;
                            default:           state <= cpu_pkg::ST_FETCH;
                        endcase
                    end
                end
                cpu_pkg::ST_ABS_LO: state <= cpu_pkg::ST_ABS_HI;
                cpu_pkg::ST_JAM:    state <= cpu_pkg::ST_JAM;   // only reset leaves
                default:            state <= cpu_pkg::ST_FETCH;
            endcase
        end
    end

    always_comb begin
        o_fetch     = 1'b0;
        o_inc_pc    = 1'b0;
        o_load_op   = 1'b0;
        o_addr_sel  = cpu_pkg::MODE_IMPL;   // bus address from pc
        o_exec      = 1'b0;
        o_write_mem = 1'b0;
        o_jump      = 1'b0;
        o_jam       = 1'b0;
        case (state)
            cpu_pkg::ST_FETCH: begin
                o_fetch  = 1'b1;
                o_inc_pc = 1'b1;
                o_exec   = pend_exec;
                o_jump   = pend_jump;
                if (pend_jump) o_addr_sel = cpu_pkg::MODE_ABS;
            end
            cpu_pkg::ST_DECODE: begin
                o_inc_pc = i_valid && (i_mode != cpu_pkg::MODE_IMPL);
                o_exec   = i_valid && (i_mode == cpu_pkg::MODE_IMPL);
            end
            cpu_pkg::ST_ZPG: begin
                o_addr_sel  = cpu_pkg::MODE_ZPG;
                o_write_mem = is_store;
            end
            cpu_pkg::ST_ABS_LO: begin
                o_load_op = 1'b1;             // keep low address byte
                o_inc_pc  = 1'b1;
            end
            cpu_pkg::ST_JMP_HI: o_load_op = 1'b1;
            cpu_pkg::ST_ABS_HI: begin
                o_addr_sel  = cpu_pkg::MODE_ABS;
                o_write_mem = is_store;
            end
            default: o_jam = 1'b1;
        endcase
    end

    assign o_rw = !o_write_mem;

    // a store takes the single data cycle right after its zero page or absolute address
    a_write_state: assert property (@(posedge i_clk) disable iff (i_rst)
        o_write_mem |->
            ((state == cpu_pkg::ST_ZPG) && ($past(state) == cpu_pkg::ST_DECODE))
         || ((state == cpu_pkg::ST_ABS_HI) && ($past(state) == cpu_pkg::ST_ABS_LO)));

endmodule

`default_nettype wire

// ==== rtl/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// program counter value after reset without a vector fetch
`define CPU_START_ADDR 16'h0200

// high address byte used by zero-page accesses
`define CPU_ZPG_PAGE 8'h00

`endif

// ==== rtl/cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_top (
    input  wire                i_clk,
    input  wire                i_rst,
    input  var cpu_pkg::data_t i_data,
    input  wire                i_ready,
    output cpu_pkg::addr_t     o_addr,
    output cpu_pkg::data_t     o_dor,
    output logic               o_rw,
    output logic               o_sync,
    output logic               o_jam
);

    logic              rdy;
    cpu_pkg::data_t    mem_data;
    cpu_pkg::data_t    opcode;
    cpu_pkg::data_t    alu_a;
    cpu_pkg::data_t    alu_b;
    cpu_pkg::data_t    alu_out;
    logic              carry;
    logic              alu_n;
    logic              alu_v;
    logic              alu_z;
    logic              alu_c;
    cpu_pkg::mode_e    mode;
    cpu_pkg::alu_op_e  alu_op;
    cpu_pkg::dst_e     dst;
    logic              uses_x;
    logic              set_c;
    logic              set_v;
    logic              flag_c_force;
    logic              valid;
    logic              inc_pc;
    logic              load_op;
    cpu_pkg::mode_e    addr_sel;
    logic              exec;
    logic              write_mem;
    logic              jump;
    cpu_pkg::state_e   state;

    cpu_regs regs_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_data(i_data), .i_ready(i_ready),
        .i_rw(o_rw), .i_state(state), .i_exec(exec), .i_write_mem(write_mem),
        .i_dst(dst), .i_uses_x(uses_x), .i_set_c(set_c), .i_set_v(set_v),
        .i_flag_c_force(flag_c_force), .i_alu_out(alu_out), .i_alu_n(alu_n),
        .i_alu_v(alu_v), .i_alu_z(alu_z), .i_alu_c(alu_c), .o_rdy(rdy),
        .o_mem_data(mem_data), .o_opcode(opcode), .o_alu_a(alu_a),
        .o_alu_b(alu_b), .o_carry(carry), .o_dor(o_dor)
    );

    cpu_decode decode_i (
        .i_opcode(opcode), .o_mode(mode), .o_alu_op(alu_op), .o_dst(dst),
        .o_uses_x(uses_x), .o_set_c(set_c), .o_set_v(set_v),
        .o_flag_c_force(flag_c_force), .o_valid(valid)
    );

    cpu_sequencer sequencer_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_rdy(rdy), .i_mode(mode),
        .i_valid(valid), .i_dst(dst), .o_fetch(o_sync), .o_inc_pc(inc_pc),
        .o_load_op(load_op), .o_addr_sel(addr_sel), .o_exec(exec),
        .o_write_mem(write_mem), .o_rw(o_rw), .o_jump(jump), .o_jam(o_jam),
        .o_state(state)
    );

    cpu_pc pc_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_rdy(rdy), .i_inc_pc(inc_pc),
        .i_jump(jump), .i_load_op(load_op), .i_addr_sel(addr_sel),
        .i_mem_data(mem_data), .o_addr(o_addr)
    );

    cpu_alu alu_i (
        .i_op(alu_op), .i_a(alu_a), .i_b(alu_b), .i_carry(carry),
        .o_out(alu_out), .o_n(alu_n), .o_v(alu_v), .o_z(alu_z), .o_c(alu_c)
    );

endmodule

`default_nettype wire

// ==== verification/cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;

    localparam cpu_pkg::addr_t START_ADDR = 16'h0200;
    localparam int             JAM_WINDOW = 20;      // cycles watched after the jam

    localparam cpu_pkg::data_t
        OP_LDA_IMM = 8'ha9,
        OP_LDA_ZPG = 8'ha5,
        OP_LDA_ABS = 8'had,
        OP_LDX_IMM = 8'ha2,
        OP_LDX_ZPG = 8'ha6,
        OP_LDX_ABS = 8'hae,
        OP_STA_ZPG = 8'h85,
        OP_STA_ABS = 8'h8d,
        OP_STX_ZPG = 8'h86,
        OP_STX_ABS = 8'h8e,
        OP_ADC_IMM = 8'h69,
        OP_ADC_ZPG = 8'h65,
        OP_SBC_IMM = 8'he9,
        OP_SBC_ABS = 8'hed,
        OP_AND_IMM = 8'h29,
        OP_ORA_ZPG = 8'h05,
        OP_EOR_IMM = 8'h49,
        OP_EOR_ABS = 8'h4d,
        OP_TAX     = 8'haa,
        OP_TXA     = 8'h8a,
        OP_INX     = 8'he8,
        OP_DEX     = 8'hca,
        OP_CLC     = 8'h18,
        OP_SEC     = 8'h38,
        OP_JMP_ABS = 8'h4c,
        OP_JAM     = 8'h02;                          // not a 6502 opcode

    logic           i_clk = 1'b0;
    logic           i_rst;
    cpu_pkg::data_t i_data;
    logic           i_ready;
    cpu_pkg::addr_t o_addr;
    cpu_pkg::data_t o_dor;
    logic           o_rw;
    logic           o_sync;
    logic           o_jam;

    cpu_pkg::data_t mem [0:65535];                   // memory behind the bus
    cpu_pkg::data_t ref_mem [0:65535];               // reference model's own copy
    cpu_pkg::addr_t exp_addr [$];
    cpu_pkg::data_t exp_data [$];

    integer         seed;
    cpu_pkg::addr_t prog_pc;
    cpu_pkg::addr_t store_ptr;
    int             n_exec;
    int             cycle_limit = 1000000;
    int             cycles = 0;
    int             store_count = 0;
    int             fetch_count = 0;
    logic           jam_seen = 1'b0;
    logic           prev_stall = 1'b0;
    cpu_pkg::addr_t prev_addr = '0;
    cpu_pkg::addr_t bus_addr = '0;                   // bus as seen at mid cycle
    cpu_pkg::data_t bus_dor = '0;
    logic           bus_rw = 1'b1;

    cpu_top dut_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_data(i_data), .i_ready(i_ready),
        .o_addr(o_addr), .o_dor(o_dor), .o_rw(o_rw), .o_sync(o_sync), .o_jam(o_jam)
    );

    always #2 i_clk = ~i_clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function automatic cpu_pkg::data_t next_rand();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic implied_instr(input cpu_pkg::data_t op);
        mem[prog_pc] = op;
        prog_pc = prog_pc + 16'd1;
    endtask

    // immediate value or zero-page address
    task automatic byte_instr(input cpu_pkg::data_t op, input cpu_pkg::data_t val);
        mem[prog_pc] = op;
        mem[prog_pc + 16'd1] = val;
        prog_pc = prog_pc + 16'd2;
    endtask

    task automatic word_instr(input cpu_pkg::data_t op, input cpu_pkg::addr_t ea);
        mem[prog_pc] = op;
        mem[prog_pc + 16'd1] = ea[7:0];              // little endian operand
        mem[prog_pc + 16'd2] = ea[15:8];
        prog_pc = prog_pc + 16'd3;
    endtask

    task automatic store_acc();
        word_instr(OP_STA_ABS, store_ptr);
        store_ptr = store_ptr + 16'd1;
    endtask

    task automatic build_program();
        cpu_pkg::data_t r;
        cpu_pkg::addr_t jmp_at;
        prog_pc   = START_ADDR;
        store_ptr = 16'h4100;
        byte_instr(OP_LDA_IMM, next_rand());         // loads and stores in all modes
        byte_instr(OP_STA_ZPG, 8'h80);
        byte_instr(OP_LDX_IMM, next_rand());
        word_instr(OP_STX_ABS, 16'h4000);
        byte_instr(OP_LDA_ZPG, 8'h10);
        word_instr(OP_STA_ABS, 16'h4001);
        byte_instr(OP_LDX_ZPG, 8'h11);
        byte_instr(OP_STX_ZPG, 8'h81);
        word_instr(OP_LDA_ABS, 16'h3005);
        byte_instr(OP_STA_ZPG, 8'h82);
        word_instr(OP_LDX_ABS, 16'h3006);
        word_instr(OP_STX_ABS, 16'h4002);
        // the second ADC and SBC of each round take the carry left by the first
        for (int i = 0; i < 6; i++) begin
            r = next_rand();
            implied_instr(r[0] ? OP_SEC : OP_CLC);
            byte_instr(OP_LDA_IMM, next_rand());
            byte_instr(OP_ADC_IMM, next_rand());
            store_acc();
            byte_instr(OP_LDA_IMM, next_rand());
            byte_instr(OP_ADC_ZPG, cpu_pkg::data_t'(8'h10 + i));
            store_acc();
            implied_instr(r[1] ? OP_SEC : OP_CLC);
            byte_instr(OP_LDA_IMM, next_rand());
            byte_instr(OP_SBC_IMM, next_rand());
            store_acc();
            byte_instr(OP_LDA_IMM, next_rand());
            word_instr(OP_SBC_ABS, cpu_pkg::addr_t'(16'h3000 + i));
            store_acc();
        end
        byte_instr(OP_LDA_IMM, next_rand());         // logic and transfers
        byte_instr(OP_AND_IMM, next_rand());
        store_acc();
        byte_instr(OP_ORA_ZPG, 8'h13);
        store_acc();
        word_instr(OP_EOR_ABS, 16'h3007);
        store_acc();
        implied_instr(OP_TAX);
        implied_instr(OP_INX);
        byte_instr(OP_STX_ZPG, 8'h83);
        implied_instr(OP_DEX);
        implied_instr(OP_DEX);
        byte_instr(OP_STX_ZPG, 8'h84);
        implied_instr(OP_TXA);
        byte_instr(OP_EOR_IMM, next_rand());
        store_acc();
        byte_instr(OP_LDX_IMM, 8'hff);
        implied_instr(OP_INX);                       // wraps to zero
        implied_instr(OP_TXA);
        store_acc();
        jmp_at = prog_pc;
        word_instr(OP_JMP_ABS, 16'h0000);            // target patched below
        for (int k = 0; k < 3; k++) begin
            byte_instr(OP_LDA_IMM, 8'hee);
            word_instr(OP_STA_ABS, cpu_pkg::addr_t'(16'h4200 + k));
        end
        mem[jmp_at + 16'd1] = prog_pc[7:0];
        mem[jmp_at + 16'd2] = prog_pc[15:8];
        byte_instr(OP_LDA_IMM, 8'h77);
        word_instr(OP_STA_ABS, 16'h4210);
        byte_instr(OP_LDA_IMM, 8'ha5);               // end marker
        word_instr(OP_STA_ABS, 16'h43ff);
        implied_instr(OP_JAM);
    endtask

    function automatic void expect_store(input cpu_pkg::addr_t ea, input cpu_pkg::data_t v);
        ref_mem[ea] = v;
        exp_addr.push_back(ea);
        exp_data.push_back(v);
    endfunction

    // instruction level model that returns the number of instructions up to the jam
    function automatic int run_reference();
        cpu_pkg::addr_t pc;
        cpu_pkg::addr_t ea;
        cpu_pkg::data_t op;
        cpu_pkg::data_t a;
        cpu_pkg::data_t x;
        cpu_pkg::data_t m;
        logic           c;
        logic [8:0]     sum;
        pc = START_ADDR;
        a  = '0;
        x  = '0;
        c  = 1'b0;
        for (int n = 1; n <= 100000; n++) begin
            op = ref_mem[pc];
            ea = '0;
            m  = '0;
            case (op)
                OP_LDA_IMM, OP_LDX_IMM, OP_ADC_IMM, OP_SBC_IMM, OP_AND_IMM, OP_EOR_IMM: begin
                    m  = ref_mem[pc + 16'd1];
                    pc = pc + 16'd2;
                end
                OP_LDA_ZPG, OP_LDX_ZPG, OP_STA_ZPG, OP_STX_ZPG, OP_ADC_ZPG, OP_ORA_ZPG: begin
                    ea = {8'h00, ref_mem[pc + 16'd1]};
                    m  = ref_mem[ea];
                    pc = pc + 16'd2;
                end
                OP_LDA_ABS, OP_LDX_ABS, OP_STA_ABS, OP_STX_ABS, OP_SBC_ABS, OP_EOR_ABS,
                OP_JMP_ABS: begin
                    ea = {ref_mem[pc + 16'd2], ref_mem[pc + 16'd1]};
                    m  = ref_mem[ea];
                    pc = pc + 16'd3;
                end
                default: pc = pc + 16'd1;
            endcase
            case (op)
                OP_LDA_IMM, OP_LDA_ZPG, OP_LDA_ABS: a = m;
                OP_LDX_IMM, OP_LDX_ZPG, OP_LDX_ABS: x = m;
                OP_STA_ZPG, OP_STA_ABS: expect_store(ea, a);
                OP_STX_ZPG, OP_STX_ABS: expect_store(ea, x);
                OP_ADC_IMM, OP_ADC_ZPG: begin
                    sum = {1'b0, a} + {1'b0, m} + {8'd0, c};
                    a   = sum[7:0];
                    c   = sum[8];
                end
                OP_SBC_IMM, OP_SBC_ABS: begin
                    sum = {1'b0, a} - {1'b0, m} - {8'd0, !c};   // carry set means no borrow
                    a   = sum[7:0];
                    c   = !sum[8];
                end
                OP_AND_IMM:             a = a & m;
                OP_ORA_ZPG:             a = a | m;
                OP_EOR_IMM, OP_EOR_ABS: a = a ^ m;
                OP_TAX:                 x = a;
                OP_TXA:                 a = x;
                OP_INX:                 x = x + 8'd1;
                OP_DEX:                 x = x - 8'd1;
                OP_CLC:                 c = 1'b0;
                OP_SEC:                 c = 1'b1;
                OP_JMP_ABS:             pc = ea;
                default:                return n;    // unknown opcode, the core stops here
            endcase
        end
        return -1;
    endfunction

    // memory answers one cycle after the address and takes writes at the clock edge
    always @(posedge i_clk) begin
        #1;
        if (!bus_rw) begin
            mem[bus_addr] = bus_dor;
        end
        i_data  = mem[bus_addr];
        i_ready = (($random(seed) & 3) != 0);        // a write cycle ignores it
    end

    // store compare and stall watch at mid cycle
    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (prev_stall) begin
                assert (o_addr == prev_addr)
                else fail_run($sformatf("ERROR at %0t: address moved from %h to %h in a stall",
                                        $time, prev_addr, o_addr));
            end
            if (!o_rw) begin
                assert (!jam_seen)
                else fail_run($sformatf("ERROR at %0t: store to %h after the jam", $time, o_addr));
                assert (o_addr[15:4] != 12'h420)
                else fail_run($sformatf("ERROR at %0t: store to %h from the skipped block",
                                        $time, o_addr));
                assert (exp_addr.size() > 0)
                else fail_run($sformatf("ERROR at %0t: store to %h beyond the expected ones",
                                        $time, o_addr));
                assert (o_addr == exp_addr[0] && o_dor == exp_data[0])
                else fail_run($sformatf("ERROR at %0t: store %0d wrote %h to %h, expected %h to %h",
                                        $time, store_count, o_dor, o_addr,
                                        exp_data[0], exp_addr[0]));
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                store_count++;
            end
            if (o_sync && i_ready) begin
                fetch_count++;                       // opcode read completed
            end
            if (o_jam) begin
                jam_seen = 1'b1;
            end
            prev_stall = o_rw && !i_ready;
            prev_addr  = o_addr;
        end
        bus_addr = o_addr;
        bus_rw   = o_rw;
        bus_dor  = o_dor;
    end

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            fail_run($sformatf("timeout: the program did not finish within %0d cycles",
                               cycle_limit));
        end
    end

    initial begin
        seed    = 32'h32ae12a8;
        i_rst   = 1'b1;
        i_data  = '0;
        i_ready = 1'b1;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ 8'h5a;
        end
        build_program();
        for (int i = 0; i < 65536; i++) begin
            ref_mem[i] = mem[i];
        end
        n_exec = run_reference();
        assert (n_exec > 0)
        else fail_run("the reference model never reached the invalid opcode");
        cycle_limit = n_exec * 16 + 100;             // 4 cycles each and 4x for stalls
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        assert (o_rw && o_sync && !o_jam && o_addr == START_ADDR)
        else fail_run($sformatf("ERROR at %0t: wrong bus state in reset, address %h",
                                $time, o_addr));
        @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        wait (jam_seen);
        repeat (JAM_WINDOW) @(posedge i_clk);
        assert (fetch_count == n_exec)
        else fail_run($sformatf("ERROR at %0t: %0d opcode fetches with sync, expected %0d",
                                $time, fetch_count, n_exec));
        if (exp_addr.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run($sformatf("ERROR at %0t: core jammed with %0d expected stores missing",
                               $time, exp_addr.size()));
        end
    end

endmodule

`default_nettype wire
